// File: source/csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// --------------------
// Datapath widths
`define CSR_XLEN         32
`define CSR_TAG_W        4

// --------------------
// Flow control
// The response queue depth is also the requester's starting credit count
`define CSR_RESP_DEPTH   4
`define CSR_RESP_CREDITS 2

// --------------------
// Identity values
`define CSR_MVENDORID    32'h0000_0612
`define CSR_MARCHID      32'h0000_0023
`define CSR_MIMPID       32'h0001_0004
`define CSR_MCONFIGPTR   32'h0000_2000

// --------------------
// CSR addresses
`define CSR_A_MSTATUS    12'h300
`define CSR_A_MTVEC      12'h305
`define CSR_A_MCYCLE     12'hB00
`define CSR_A_MINSTRET   12'hB02
`define CSR_A_CYCLE      12'hC00
`define CSR_A_INSTRET    12'hC02
`define CSR_A_MVENDORID  12'hF11
`define CSR_A_MARCHID    12'hF12
`define CSR_A_MIMPID     12'hF13
`define CSR_A_MHARTID    12'hF14
`define CSR_A_MCONFIGPTR 12'hF15

`endif

// File: source/csr_pkg.sv
`default_nettype none

`include "csr_cfg.svh"

package csr_pkg;

    // --------------------
    // Vector types
    typedef logic [`CSR_XLEN-1:0]  xlen_t;
    typedef logic [11:0]           csr_addr_t;
    typedef logic [`CSR_TAG_W-1:0] csr_tag_t;

    typedef enum logic [1:0] {
        CSR_RD = 2'd0,  // Plain read with no side effect
        CSR_RW = 2'd1,
        CSR_RS = 2'd2,
        CSR_RC = 2'd3
    } csr_op_e;

    // --------------------
    // Bundles
    typedef struct packed {
        csr_op_e   op;
        csr_addr_t addr;
        xlen_t     wdata;
        csr_tag_t  tag;
    } csr_req_t;

    typedef struct packed {
        csr_tag_t tag;
        xlen_t    rdata;    // Value before the access
        logic     illegal;
    } csr_resp_t;

    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        xlen_t     data;
    } csr_wr_t;

    typedef struct packed {
        logic valid;
        logic is_uop_final;  // Last micro-op of an instruction
    } retire_t;

endpackage

`default_nettype wire

// File: source/csr_counters.sv
`default_nettype none

`include "csr_cfg.svh"

module csr_counters (
    input  logic               clk,
    input  logic               rstn,
    input  csr_pkg::csr_addr_t rd_addr,
    output csr_pkg::xlen_t     rd_data,
    output logic               rd_hit,
    input  csr_pkg::csr_wr_t   wr,
    input  csr_pkg::retire_t   retire
);

    csr_pkg::xlen_t cycle_q;
    csr_pkg::xlen_t instret_q;
    logic           wr_cycle;
    logic           wr_instret;
    logic           retire_final;

    // Only the machine addresses take writes
    assign wr_cycle     = wr.en && (wr.addr == `CSR_A_MCYCLE);
    assign wr_instret   = wr.en && (wr.addr == `CSR_A_MINSTRET);
    assign retire_final = retire.valid && retire.is_uop_final;

    // --------------------
    // Counter update
    always_ff @(posedge clk) begin
        if (!rstn) begin
            cycle_q   <= '0;
            instret_q <= '0;
        end else begin
            if (wr_cycle) begin
                cycle_q <= wr.data;              // Written value replaces this tick
            end else begin
                cycle_q <= cycle_q + 1'b1;
            end

            if (wr_instret) begin
                instret_q <= wr.data;            // Write wins over a retire
            end else if (retire_final) begin
                instret_q <= instret_q + 1'b1;
            end
        end
    end

    // --------------------
    // Read decode
    always_comb begin
        rd_data = '0;
        rd_hit  = 1'b1;
        case (rd_addr)
            `CSR_A_MCYCLE,
            `CSR_A_CYCLE:     rd_data = cycle_q;
            `CSR_A_MINSTRET,
            `CSR_A_INSTRET:   rd_data = instret_q;
            default:          rd_hit  = 1'b0;  // Not one of ours
        endcase
    end

endmodule

`default_nettype wire

// File: source/csr_machine_regs.sv
`default_nettype none

`include "csr_cfg.svh"

module csr_machine_regs #(
    parameter csr_pkg::xlen_t HARTID = '0
) (
    input  logic               clk,
    input  logic               rstn,
    input  csr_pkg::csr_addr_t rd_addr,
    output csr_pkg::xlen_t     rd_data,
    output logic               rd_hit,
    input  csr_pkg::csr_wr_t   wr
);

    localparam int MIE_BIT  = 3;
    localparam int MPIE_BIT = 7;
    localparam int MPP_LSB  = 11;

    logic           mie_q;
    logic           mpie_q;
    csr_pkg::xlen_t mtvec_q;
    csr_pkg::xlen_t mstatus_rd;
    logic           wr_mstatus;
    logic           wr_mtvec;

    assign wr_mstatus = wr.en && (wr.addr == `CSR_A_MSTATUS);
    assign wr_mtvec   = wr.en && (wr.addr == `CSR_A_MTVEC);

    // --------------------
    // mstatus
    // Only MIE and MPIE are stored, the rest is fixed
    always_ff @(posedge clk) begin
        if (!rstn) begin
            mie_q  <= 1'b0;
            mpie_q <= 1'b0;
        end else if (wr_mstatus) begin
            mie_q  <= wr.data[MIE_BIT];
            mpie_q <= wr.data[MPIE_BIT];
        end
    end

    always_comb begin
        mstatus_rd                 = '0;
        mstatus_rd[MIE_BIT]        = mie_q;
        mstatus_rd[MPIE_BIT]       = mpie_q;
        mstatus_rd[MPP_LSB +: 2]   = 2'b11;  // Machine mode only
    end

    // --------------------
    // mtvec
    always_ff @(posedge clk) begin
        if (!rstn) begin
            mtvec_q <= '0;
        end else if (wr_mtvec) begin
            mtvec_q[`CSR_XLEN-1:2] <= wr.data[`CSR_XLEN-1:2];
            if (!wr.data[1]) begin
                mtvec_q[1:0] <= wr.data[1:0];  // Modes 2 and 3 are reserved
            end
        end
    end

    // --------------------
    // Read decode
    always_comb begin
        rd_data = '0;
        rd_hit  = 1'b1;
        case (rd_addr)
            `CSR_A_MSTATUS:    rd_data = mstatus_rd;
            `CSR_A_MTVEC:      rd_data = mtvec_q;
            `CSR_A_MVENDORID:  rd_data = `CSR_MVENDORID;
            `CSR_A_MARCHID:    rd_data = `CSR_MARCHID;
            `CSR_A_MIMPID:     rd_data = `CSR_MIMPID;
            `CSR_A_MHARTID:    rd_data = HARTID;
            `CSR_A_MCONFIGPTR: rd_data = `CSR_MCONFIGPTR;
            default:           rd_hit  = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/csr_access_ctrl.sv
`default_nettype none

`include "csr_cfg.svh"

module csr_access_ctrl (
    input  logic               clk,
    input  logic               rstn,
    input  csr_pkg::csr_req_t  req,
    input  logic               req_valid,
    output logic               req_credit,
    output csr_pkg::csr_resp_t resp,
    output logic               resp_valid,
    input  logic               resp_credit,
    output csr_pkg::csr_addr_t rd_addr,
    input  csr_pkg::xlen_t     cnt_rd_data,
    input  csr_pkg::xlen_t     mach_rd_data,
    input  logic               cnt_rd_hit,
    input  logic               mach_rd_hit,
    output csr_pkg::csr_wr_t   wr
);

    localparam int DEPTH  = `CSR_RESP_DEPTH;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int CRED_W = $clog2(`CSR_RESP_CREDITS + 1);

    csr_pkg::xlen_t     old_val;
    csr_pkg::xlen_t     new_val;
    logic               is_write;
    logic               illegal;
    csr_pkg::csr_resp_t push_entry;
    logic               push;
    logic               pop;

    csr_pkg::csr_resp_t fifo_mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   fill_q;
    logic [CNT_W-1:0]   outstanding_q;
    logic [CRED_W-1:0]  resp_cred_q;
    logic               req_credit_q;

    // --------------------
    // Request decode
    assign rd_addr  = req.addr;
    assign old_val  = cnt_rd_hit ? cnt_rd_data : mach_rd_data;
    assign is_write = (req.op != csr_pkg::CSR_RD);
    // Address bits 11:10 both set mark a read-only CSR
    assign illegal  = !(cnt_rd_hit || mach_rd_hit) || (is_write && (&req.addr[11:10]));

    always_comb begin
        case (req.op)
            csr_pkg::CSR_RW: new_val = req.wdata;
            csr_pkg::CSR_RS: new_val = old_val | req.wdata;
            csr_pkg::CSR_RC: new_val = old_val & ~req.wdata;
            default:         new_val = old_val;
        endcase
    end

    assign wr.en   = req_valid && is_write && !illegal;
    assign wr.addr = req.addr;
    assign wr.data = new_val;

    assign push_entry.tag     = req.tag;
    assign push_entry.rdata   = illegal ? '0 : old_val;
    assign push_entry.illegal = illegal;

    // --------------------
    // Response queue
    assign push       = req_valid;
    assign resp_valid = (fill_q != '0) && (resp_cred_q != '0);
    assign pop        = resp_valid;          // Consumer always accepts under credit
    assign resp       = fifo_mem[rd_ptr_q];
    assign req_credit = req_credit_q;

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr_q] <= push_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            fill_q <= fill_q + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // --------------------
    // Credit loops
    always_ff @(posedge clk) begin
        if (!rstn) begin
            req_credit_q  <= 1'b0;
            outstanding_q <= '0;
            resp_cred_q   <= CRED_W'(`CSR_RESP_CREDITS);
        end else begin
            req_credit_q  <= pop;            // Slot returns the cycle after it drains
            outstanding_q <= outstanding_q + CNT_W'(req_valid) - CNT_W'(req_credit_q);
            resp_cred_q   <= resp_cred_q + CRED_W'(resp_credit) - CRED_W'(pop);
        end
    end

    // The requester must hold a credit for every request it presents
    ap_req_has_credit: assert property (
        @(posedge clk) disable iff (!rstn)
        req_valid |-> outstanding_q < CNT_W'(DEPTH)
    );

    // The consumer never returns more credits than it has slots
    ap_resp_cred_bound: assert property (
        @(posedge clk) disable iff (!rstn)
        resp_cred_q <= CRED_W'(`CSR_RESP_CREDITS)
    );

    // The two banks decode disjoint address sets
    ap_one_bank_hit: assert property (
        @(posedge clk) disable iff (!rstn)
        $onehot0({cnt_rd_hit, mach_rd_hit})
    );

endmodule

`default_nettype wire

// File: source/csr_unit.sv
`default_nettype none

module csr_unit #(
    parameter csr_pkg::xlen_t HARTID = '0
) (
    input  logic               clk,
    input  logic               rstn,
    input  csr_pkg::csr_req_t  req,
    input  logic               req_valid,
    output logic               req_credit,
    input  csr_pkg::retire_t   retire,
    output csr_pkg::csr_resp_t resp,
    output logic               resp_valid,
    input  logic               resp_credit
);

    csr_pkg::csr_addr_t rd_addr;
    csr_pkg::xlen_t     cnt_rd_data;
    csr_pkg::xlen_t     mach_rd_data;
    logic               cnt_rd_hit;
    logic               mach_rd_hit;
    csr_pkg::csr_wr_t   wr;

    // --------------------
    // Register banks side by side
    csr_counters counters0 (
        .clk     (clk),
        .rstn    (rstn),
        .rd_addr (rd_addr),
        .rd_data (cnt_rd_data),
        .rd_hit  (cnt_rd_hit),
        .wr      (wr),
        .retire  (retire)
    );

    csr_machine_regs #(
        .HARTID (HARTID)
    ) mach_regs0 (
        .clk     (clk),
        .rstn    (rstn),
        .rd_addr (rd_addr),
        .rd_data (mach_rd_data),
        .rd_hit  (mach_rd_hit),
        .wr      (wr)
    );

    // --------------------
    // Access control and response queue
    csr_access_ctrl ctrl0 (
        .clk          (clk),
        .rstn         (rstn),
        .req          (req),
        .req_valid    (req_valid),
        .req_credit   (req_credit),
        .resp         (resp),
        .resp_valid   (resp_valid),
        .resp_credit  (resp_credit),
        .rd_addr      (rd_addr),
        .cnt_rd_data  (cnt_rd_data),
        .mach_rd_data (mach_rd_data),
        .cnt_rd_hit   (cnt_rd_hit),
        .mach_rd_hit  (mach_rd_hit),
        .wr           (wr)
    );

endmodule

`default_nettype wire

// File: test/csr_unit_tb.sv
`default_nettype none

`include "csr_cfg.svh"

module csr_unit_tb;

    localparam csr_pkg::xlen_t HARTID = 32'h0000_0005;

    logic               clk;
    logic               rstn;
    csr_pkg::csr_req_t  req;
    logic               req_valid;
    logic               req_credit;
    csr_pkg::retire_t   retire;
    csr_pkg::csr_resp_t resp;
    logic               resp_valid;
    logic               resp_credit;

    csr_pkg::csr_resp_t exp_q[$];
    csr_pkg::csr_resp_t exp_r;
    int                 due_q[$];           // Edge numbers at which a response credit returns
    int                 cur_edge = 0;
    int                 errors = 0;
    int                 req_credits = `CSR_RESP_DEPTH;
    int                 tb_resp_cred = `CSR_RESP_CREDITS;
    int                 credit_pulses = 0;
    int                 resp_count = 0;
    int                 sent_count = 0;
    bit                 hold = 1'b0;
    logic [31:0]        seed = 32'h8c05;
    csr_pkg::csr_tag_t  next_tag = '0;
    csr_pkg::csr_addr_t addr_pool [14];

    // Shadow state of the registers
    csr_pkg::xlen_t     sh_cyc_val = '0;
    int                 sh_cyc_edge = 8;    // Counter reads zero after the last reset edge
    csr_pkg::xlen_t     sh_instret = '0;
    csr_pkg::xlen_t     sh_mstatus = 32'h0000_1800;
    csr_pkg::xlen_t     sh_mtvec = '0;

    csr_unit #(.HARTID(HARTID)) dut0 (
        .clk         (clk),
        .rstn        (rstn),
        .req         (req),
        .req_valid   (req_valid),
        .req_credit  (req_credit),
        .retire      (retire),
        .resp        (resp),
        .resp_valid  (resp_valid),
        .resp_credit (resp_credit)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cur_edge <= cur_edge + 1;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("Timeout while waiting for %s", what);
        finish_run();
    endtask

    // --------------------
    // Reference model for one cycle, with or without a request
    function automatic csr_pkg::csr_resp_t model_cycle(input bit send, input csr_pkg::csr_op_e op,
            input csr_pkg::csr_addr_t addr, input csr_pkg::xlen_t wdata,
            input csr_pkg::csr_tag_t tag, input csr_pkg::retire_t rt, input int n);
        csr_pkg::csr_resp_t r;
        csr_pkg::xlen_t     old_v;
        csr_pkg::xlen_t     new_v;
        logic               hit;
        logic               ill;
        logic               wr_ir;
        hit   = 1'b1;
        wr_ir = 1'b0;
        old_v = '0;
        case (addr)
            `CSR_A_MCYCLE, `CSR_A_CYCLE:     old_v = sh_cyc_val + 32'(n - sh_cyc_edge);
            `CSR_A_MINSTRET, `CSR_A_INSTRET: old_v = sh_instret;
            `CSR_A_MSTATUS:    old_v = sh_mstatus;
            `CSR_A_MTVEC:      old_v = sh_mtvec;
            `CSR_A_MVENDORID:  old_v = `CSR_MVENDORID;
            `CSR_A_MARCHID:    old_v = `CSR_MARCHID;
            `CSR_A_MIMPID:     old_v = `CSR_MIMPID;
            `CSR_A_MHARTID:    old_v = HARTID;
            `CSR_A_MCONFIGPTR: old_v = `CSR_MCONFIGPTR;
            default:           hit = 1'b0;
        endcase
        ill = !hit || (op != csr_pkg::CSR_RD && addr[11:10] == 2'b11);
        case (op)
            csr_pkg::CSR_RW: new_v = wdata;
            csr_pkg::CSR_RS: new_v = old_v | wdata;
            csr_pkg::CSR_RC: new_v = old_v & ~wdata;
            default:         new_v = old_v;
        endcase
        if (send && op != csr_pkg::CSR_RD && !ill) begin
            case (addr)
                `CSR_A_MCYCLE: begin
                    sh_cyc_val  = new_v;
                    sh_cyc_edge = n + 1;  // Value holds after the next edge
                end
                `CSR_A_MINSTRET: begin
                    sh_instret = new_v;
                    wr_ir      = 1'b1;
                end
                `CSR_A_MSTATUS: sh_mstatus = (new_v & 32'h0000_0088) | 32'h0000_1800;
                `CSR_A_MTVEC:   sh_mtvec = {new_v[31:2], new_v[1] ? sh_mtvec[1:0] : new_v[1:0]};
                default: ;
            endcase
        end
        if (rt.valid && rt.is_uop_final && !wr_ir) sh_instret = sh_instret + 1;
        r.tag     = tag;
        r.rdata   = ill ? '0 : old_v;
        r.illegal = ill;
        return r;
    endfunction

    task automatic drive_cycle(input bit send, input csr_pkg::csr_op_e op,
            input csr_pkg::csr_addr_t addr, input csr_pkg::xlen_t wdata,
            input csr_pkg::retire_t rt);
        csr_pkg::csr_resp_t e;
        @(posedge clk);
        #2;
        e = model_cycle(send, op, addr, wdata, next_tag, rt, cur_edge);
        req.op    = op;
        req.addr  = addr;
        req.wdata = wdata;
        req.tag   = next_tag;
        req_valid = send;
        retire    = rt;
        if (send) begin
            exp_q.push_back(e);
            req_credits--;
            sent_count++;
            next_tag++;
        end
    endtask

    task automatic idle_cycles(input int n, input csr_pkg::retire_t rt);
        repeat (n) drive_cycle(1'b0, csr_pkg::CSR_RD, '0, '0, rt);
    endtask

    task automatic send_req(input csr_pkg::csr_op_e op, input csr_pkg::csr_addr_t addr,
            input csr_pkg::xlen_t wdata, input csr_pkg::retire_t rt);
        int waited;
        waited = 0;
        while (req_credits == 0) begin
            if (waited == 200) report_timeout("a request credit");
            idle_cycles(1, '0);
            waited++;
        end
        drive_cycle(1'b1, op, addr, wdata, rt);
    endtask

    // --------------------
    // Response credit return with random delay
    initial begin
        resp_credit = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            if (!hold && due_q.size() > 0 && due_q[0] <= cur_edge) begin
                void'(due_q.pop_front());
                resp_credit = 1'b1;
                tb_resp_cred++;
            end else begin
                resp_credit = 1'b0;
            end
        end
    end

    // --------------------
    // Compare process
    always @(negedge clk) begin
        if (rstn) begin
            if (req_credit) begin
                req_credits++;
                credit_pulses++;
            end
            if (resp_valid) begin
                resp_count++;
                if (tb_resp_cred == 0) begin
                    errors++;
                    $display("A response appeared although no response credit was held");
                end else begin
                    tb_resp_cred--;
                end
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("A response appeared with no request outstanding");
                end else begin
                    exp_r = exp_q.pop_front();
                    check_val("resp.tag", resp.tag, exp_r.tag);
                    check_val("resp.rdata", resp.rdata, exp_r.rdata);
                    check_val("resp.illegal", resp.illegal, exp_r.illegal);
                end
                due_q.push_back(cur_edge + 1 + int'(lcg_next() % 32'd6));
            end
        end
    end

    initial begin
        csr_pkg::xlen_t     r;
        csr_pkg::csr_addr_t a;
        int                 waited;
        addr_pool = '{`CSR_A_MSTATUS, `CSR_A_MTVEC, `CSR_A_MCYCLE, `CSR_A_MINSTRET,
                      `CSR_A_CYCLE, `CSR_A_INSTRET, `CSR_A_MVENDORID, `CSR_A_MARCHID,
                      `CSR_A_MIMPID, `CSR_A_MHARTID, `CSR_A_MCONFIGPTR, 12'h340,
                      12'h7C0, 12'hB03};
        rstn      = 1'b0;
        req       = '0;
        req_valid = 1'b0;
        retire    = '0;
        repeat (8) @(posedge clk);
        #2;
        rstn = 1'b1;

        // Counters with known retire pulses
        send_req(csr_pkg::CSR_RW, `CSR_A_MCYCLE, lcg_next(), '0);
        send_req(csr_pkg::CSR_RW, `CSR_A_MINSTRET, lcg_next(), 2'b11);  // Write beats retire
        idle_cycles(1, 2'b11);
        idle_cycles(1, 2'b10);
        idle_cycles(1, 2'b01);
        idle_cycles(1, 2'b11);
        send_req(csr_pkg::CSR_RD, `CSR_A_CYCLE, '0, 2'b11);
        send_req(csr_pkg::CSR_RD, `CSR_A_MCYCLE, '0, '0);
        send_req(csr_pkg::CSR_RD, `CSR_A_INSTRET, '0, 2'b11);
        send_req(csr_pkg::CSR_RD, `CSR_A_MINSTRET, '0, '0);
        idle_cycles(3, 2'b11);
        send_req(csr_pkg::CSR_RS, `CSR_A_MCYCLE, lcg_next(), '0);
        send_req(csr_pkg::CSR_RC, `CSR_A_MINSTRET, lcg_next(), 2'b11);
        send_req(csr_pkg::CSR_RW, `CSR_A_CYCLE, lcg_next(), '0);
        send_req(csr_pkg::CSR_RD, `CSR_A_CYCLE, '0, '0);
        send_req(csr_pkg::CSR_RD, `CSR_A_INSTRET, '0, '0);

        // --------------------
        // WARL registers
        repeat (24) begin
            r = lcg_next();
            a = r[8] ? `CSR_A_MSTATUS : `CSR_A_MTVEC;
            send_req(csr_pkg::csr_op_e'(2'(r[1:0] % 3) + 2'd1), a, lcg_next(), '0);
        end
        send_req(csr_pkg::CSR_RD, `CSR_A_MSTATUS, '0, '0);
        send_req(csr_pkg::CSR_RD, `CSR_A_MTVEC, '0, '0);

        // Identity registers are read only
        for (int i = 0; i < 5; i++) begin
            a = `CSR_A_MVENDORID + 12'(i);
            r = lcg_next();
            send_req(csr_pkg::CSR_RD, a, '0, '0);
            send_req(csr_pkg::csr_op_e'(2'(r[1:0] % 3) + 2'd1), a, lcg_next(), '0);
            send_req(csr_pkg::CSR_RD, a, '0, '0);
        end

        // Unimplemented addresses
        foreach (addr_pool[i]) begin
            if (i >= 11) send_req(csr_pkg::CSR_RW, addr_pool[i], lcg_next(), '0);
        end
        send_req(csr_pkg::CSR_RD, 12'h001, '0, '0);
        send_req(csr_pkg::CSR_RD, `CSR_A_MSTATUS, '0, '0);
        send_req(csr_pkg::CSR_RD, `CSR_A_MTVEC, '0, '0);
        send_req(csr_pkg::CSR_RD, `CSR_A_MINSTRET, '0, '0);

        // --------------------
        // Withheld response credits fill the queue
        hold = 1'b1;
        repeat (12) begin
            if (req_credits != 0) begin
                send_req(csr_pkg::CSR_RD, `CSR_A_MIMPID, '0, '0);
            end else begin
                idle_cycles(1, '0);
            end
        end
        idle_cycles(10, '0);
        check_val("req_credits", req_credits, 0);  // Queue full, requester starved
        hold = 1'b0;

        // Mixed random traffic
        repeat (80) begin
            r = lcg_next();
            if (r[31:29] == 3'd0) begin
                idle_cycles(1, r[3:2]);
            end else begin
                send_req(csr_pkg::csr_op_e'(r[1:0]), addr_pool[r[7:4] % 14], lcg_next(), r[3:2]);
            end
        end
        idle_cycles(1, '0);

        waited = 0;
        while (exp_q.size() != 0 || req_credits != `CSR_RESP_DEPTH) begin
            if (waited == 500) report_timeout("the response queue to drain");
            idle_cycles(1, '0);
            waited++;
        end
        check_val("req_credit pulses", credit_pulses, resp_count);
        check_val("responses", resp_count, sent_count);
        finish_run();
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+source
source/csr_pkg.sv
source/csr_counters.sv
source/csr_machine_regs.sv
source/csr_access_ctrl.sv
source/csr_unit.sv
test/csr_unit_tb.sv

// File: Bender.yml
package:
  name: csr_unit

export_include_dirs:
  - source

sources:
  - files:
      - source/csr_pkg.sv
      - source/csr_counters.sv
      - source/csr_machine_regs.sv
      - source/csr_access_ctrl.sv
      - source/csr_unit.sv
  - target: test
    files:
      - test/csr_unit_tb.sv
